// File: common/fphub_defines.svh
// Width, bias and SRT timing macros for the HUB divider, included by RTL and testbench
`ifndef FPHUB_DEFINES_SVH
`define FPHUB_DEFINES_SVH

// Stored mantissa field width
`define FPHUB_M 23

// Biased exponent field width
`define FPHUB_E 8

// Exponent bias of the single-precision layout
`define FPHUB_BIAS 127

// All-ones exponent, reserved for inf and NaN
`define FPHUB_EXP_MAX 255

// HUB significand {1, mantissa, 1}
`define FPHUB_SIG_W (`FPHUB_M + 2)

// Digits produced by the SRT loop
// Two more than the significand needs, the quotient is scaled back down
`define SRT_ITERS 27

// Accepted start to finish, normal operands
`define SRT_LATENCY (`SRT_ITERS + 2)

`endif

// File: common/fphub_format_pkg.sv
// Types for the HUB floating-point word, its significand and operand classes, used by RTL and testbench
`include "fphub_defines.svh"

package fphub_format_pkg;

    // Full operand or result
    // Sign, biased exponent, stored mantissa
    typedef logic [`FPHUB_E+`FPHUB_M:0] fphub_word_t;

    // Significand with implicit leading one and implicit HUB one
    typedef logic [`FPHUB_SIG_W-1:0] fphub_sig_t;

    // Integer quotient floor(Sx * 2^24 / Sd)
    // Always in [2^23, 2^25)
    typedef logic [`FPHUB_SIG_W-1:0] fphub_quot_t;

    // Signed exponent with headroom
    // Catches both overflow above 254 and underflow below 1
    typedef logic signed [`FPHUB_E+2:0] fphub_exp_calc_t;

    // Operand class decoded from exponent and mantissa
    // No denormals in HUB, exponent 0 is always zero
    typedef enum logic [1:0] {
        class_normal,
        class_zero,
        class_inf,
        class_nan
    } fphub_class_e;

endpackage

// File: common/srt_pkg.sv
// Types for the radix-2 SRT iteration control and quotient digits, used by the SRT blocks and testbench
`include "fphub_defines.svh"

package srt_pkg;

    // Operation sequence
    typedef enum logic [1:0] {
        st_idle,
        st_iterate,
        st_pack
    } srt_state_e;

    // Redundant quotient digit {-1, 0, +1}
    typedef enum logic [1:0] {
        digit_neg,
        digit_zero,
        digit_pos
    } srt_digit_e;

    // Partial remainder, two's complement
    // Sign, one integer bit, 26 fraction bits
    typedef logic signed [`FPHUB_SIG_W+2:0] srt_rem_t;

    // Iteration counter
    typedef logic [$clog2(`SRT_ITERS+1)-1:0] srt_count_t;

endpackage

// File: source/fphub_special_cases.sv
// Operand classifier and special-result former of the HUB divider, instantiated by the top level
`timescale 1ns/1ps
`include "fphub_defines.svh"

module fphub_special_cases (
    input  fphub_format_pkg::fphub_word_t x,
    input  fphub_format_pkg::fphub_word_t d,
    output logic                         is_special,
    output fphub_format_pkg::fphub_word_t special_res
);

    fphub_format_pkg::fphub_class_e x_cls;
    fphub_format_pkg::fphub_class_e d_cls;
    logic                           res_sign;
    logic                           any_nan;

    // Decode one operand from its exponent and mantissa fields
    function automatic fphub_format_pkg::fphub_class_e classify(
        input fphub_format_pkg::fphub_word_t w
    );
        logic [`FPHUB_E-1:0] e;
        logic [`FPHUB_M-1:0] m;
        e = w[`FPHUB_E+`FPHUB_M-1:`FPHUB_M];
        m = w[`FPHUB_M-1:0];
        if (e == '0) begin
            return fphub_format_pkg::class_zero;
        end
        if (e == {`FPHUB_E{1'b1}}) begin
            // Zero mantissa is inf, anything else NaN
            return (m == '0) ? fphub_format_pkg::class_inf : fphub_format_pkg::class_nan;
        end
        return fphub_format_pkg::class_normal;
    endfunction

    assign x_cls    = classify(x);
    assign d_cls    = classify(d);
    assign res_sign = x[`FPHUB_E+`FPHUB_M] ^ d[`FPHUB_E+`FPHUB_M];

    // Only normal/normal goes through the SRT loop
    assign is_special = (x_cls != fphub_format_pkg::class_normal) ||
                        (d_cls != fphub_format_pkg::class_normal);

    // NaN in, 0/0 and inf/inf all collapse to the canonical NaN
    assign any_nan = (x_cls == fphub_format_pkg::class_nan) ||
                     (d_cls == fphub_format_pkg::class_nan) ||
                     (x_cls == fphub_format_pkg::class_zero &&
                      d_cls == fphub_format_pkg::class_zero) ||
                     (x_cls == fphub_format_pkg::class_inf &&
                      d_cls == fphub_format_pkg::class_inf);

    always_comb begin
        if (any_nan) begin
            special_res = {1'b0, {`FPHUB_E{1'b1}}, {`FPHUB_M{1'b1}}};
        end else if (x_cls == fphub_format_pkg::class_zero ||
                     d_cls == fphub_format_pkg::class_inf) begin
            // 0/finite or finite/inf, signed zero
            special_res = {res_sign, {`FPHUB_E{1'b0}}, {`FPHUB_M{1'b0}}};
        end else if (x_cls == fphub_format_pkg::class_inf ||
                     d_cls == fphub_format_pkg::class_zero) begin
            // inf/finite or finite/0, signed inf
            special_res = {res_sign, {`FPHUB_E{1'b1}}, {`FPHUB_M{1'b0}}};
        end else begin
            // Unused, is_special is low
            special_res = '0;
        end
    end

endmodule

// File: srt_divider/srt_control.sv
// Operation FSM and iteration counter of the SRT divider, instantiated by the HUB divider top level
`timescale 1ns/1ps
`include "fphub_defines.svh"

module srt_control (
    input  logic clk,
    input  logic rst_l,
    input  logic start,
    input  logic is_special,
    output logic load_normal,
    output logic load_special,
    output logic iterate,
    output logic pack,
    output logic busy
);

    srt_pkg::srt_state_e state;
    srt_pkg::srt_state_e state_nxt;
    srt_pkg::srt_count_t count;
    logic                accept;
    // Result still being registered downstream
    logic                drain_q;

    // Start only counts when nothing is in flight
    assign accept       = start && !busy;
    assign load_special = accept && is_special;
    assign load_normal  = accept && !is_special;

    assign iterate = (state == srt_pkg::st_iterate);
    assign pack    = (state == srt_pkg::st_pack);
    // Stays high until the edge that raises finish
    assign busy    = (state != srt_pkg::st_idle) || drain_q;

    always_comb begin
        state_nxt = state;
        case (state)
            srt_pkg::st_idle: begin
                // Specials finish without leaving idle
                if (load_normal) begin
                    state_nxt = srt_pkg::st_iterate;
                end
            end
            srt_pkg::st_iterate: begin
                if (count == srt_pkg::srt_count_t'(`SRT_ITERS - 1)) begin
                    state_nxt = srt_pkg::st_pack;
                end
            end
            srt_pkg::st_pack: state_nxt = srt_pkg::st_idle;
            default:          state_nxt = srt_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            state   <= srt_pkg::st_idle;
            count   <= '0;
            drain_q <= 1'b0;
        end else begin
            state   <= state_nxt;
            drain_q <= pack | load_special;
            // One count per digit
            if (load_normal) begin
                count <= '0;
            end else if (iterate) begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

// File: srt_divider/srt_datapath.sv
// Radix-2 SRT remainder recurrence and quotient digit store, instantiated by the HUB divider top level
`timescale 1ns/1ps
`include "fphub_defines.svh"

module srt_datapath (
    input  logic                         clk,
    input  logic                         rst_l,
    input  logic                         load_normal,
    input  logic                         iterate,
    input  fphub_format_pkg::fphub_word_t x,
    input  fphub_format_pkg::fphub_word_t d,
    output fphub_format_pkg::fphub_quot_t quotient
);

    // One half in the remainder format, 26 fraction bits
    localparam srt_pkg::srt_rem_t HALF = srt_pkg::srt_rem_t'(1) <<< `FPHUB_SIG_W;

    // HUB significands {1, mantissa, 1}
    fphub_format_pkg::fphub_sig_t sx;
    fphub_format_pkg::fphub_sig_t sd;

    // Remainder and divisor, same fixed-point format
    srt_pkg::srt_rem_t rem_q;
    srt_pkg::srt_rem_t div_q;
    srt_pkg::srt_rem_t rem_two;
    srt_pkg::srt_rem_t rem_nxt;

    srt_pkg::srt_digit_e digit;

    // Digit store, first digit ends up in the MSB
    logic [`SRT_ITERS-1:0] pos_q;
    logic [`SRT_ITERS-1:0] neg_q;
    logic [`SRT_ITERS-1:0] q_full;

    assign sx = {1'b1, x[`FPHUB_M-1:0], 1'b1};
    assign sd = {1'b1, d[`FPHUB_M-1:0], 1'b1};

    assign rem_two = rem_q <<< 1;

    // Digit selection on 2w against +-1/2
    always_comb begin
        if (rem_two >= HALF) begin
            digit = srt_pkg::digit_pos;
        end else if (rem_two < -HALF) begin
            digit = srt_pkg::digit_neg;
        end else begin
            digit = srt_pkg::digit_zero;
        end
    end

    // w' = 2w - q*d
    always_comb begin
        case (digit)
            srt_pkg::digit_pos: rem_nxt = rem_two - div_q;
            srt_pkg::digit_neg: rem_nxt = rem_two + div_q;
            default:            rem_nxt = rem_two;
        endcase
    end

    // Divisor Sd / 2^25 is held as 2*Sd at 26 fraction bits
    always_ff @(posedge clk) begin
        if (load_normal) begin
            div_q <= {2'b00, sd, 1'b0};
        end
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            rem_q <= '0;
            pos_q <= '0;
            neg_q <= '0;
        end else if (load_normal) begin
            // w0 = x/2, so Sx lands one bit lower than the divisor
            rem_q <= {3'b000, sx};
            pos_q <= '0;
            neg_q <= '0;
        end else if (iterate) begin
            rem_q <= rem_nxt;
            pos_q <= {pos_q[`SRT_ITERS-2:0], digit == srt_pkg::digit_pos};
            neg_q <= {neg_q[`SRT_ITERS-2:0], digit == srt_pkg::digit_neg};
        end
    end

    // Non-redundant form, one less when the last remainder is negative
    // Gives floor(Sx * 2^(SRT_ITERS-1) / Sd)
    assign q_full = pos_q - neg_q
                  - {{(`SRT_ITERS-1){1'b0}}, rem_q[`FPHUB_SIG_W+2]};

    // Drop the extra digits to reach Q = floor(Sx * 2^24 / Sd)
    assign quotient = q_full[`SRT_ITERS-1:`SRT_ITERS-`FPHUB_SIG_W];

endmodule

// File: source/fphub_result_pack.sv
// Result sign, exponent, normalization and range check of the HUB divider, instantiated by the top level
`timescale 1ns/1ps
`include "fphub_defines.svh"

module fphub_result_pack (
    input  logic                         clk,
    input  logic                         rst_l,
    input  logic                         load_normal,
    input  logic                         load_special,
    input  logic                         pack,
    input  fphub_format_pkg::fphub_word_t x,
    input  fphub_format_pkg::fphub_word_t d,
    input  fphub_format_pkg::fphub_word_t special_res,
    input  fphub_format_pkg::fphub_quot_t quotient,
    output fphub_format_pkg::fphub_word_t res,
    output logic                         finish
);

    // Latched at start
    logic                              sign_q;
    fphub_format_pkg::fphub_exp_calc_t exp_q;

    // Normalized candidate
    fphub_format_pkg::fphub_exp_calc_t exp_adj;
    logic [`FPHUB_M-1:0]               mant;
    fphub_format_pkg::fphub_word_t     norm_word;

    // Word waiting one cycle before it is presented
    fphub_format_pkg::fphub_word_t     stage_q;
    logic                              pend_q;

    always_ff @(posedge clk) begin
        if (load_normal) begin
            sign_q <= x[`FPHUB_E+`FPHUB_M] ^ d[`FPHUB_E+`FPHUB_M];
            exp_q  <= fphub_format_pkg::fphub_exp_calc_t'({3'b000, x[`FPHUB_E+`FPHUB_M-1:`FPHUB_M]})
                    - fphub_format_pkg::fphub_exp_calc_t'({3'b000, d[`FPHUB_E+`FPHUB_M-1:`FPHUB_M]})
                    + fphub_format_pkg::fphub_exp_calc_t'(`FPHUB_BIAS);
        end
    end

    // One-position normalization
    // Q >= 2^24 keeps the exponent, otherwise shift left and lose one
    always_comb begin
        if (quotient[`FPHUB_SIG_W-1]) begin
            mant    = quotient[`FPHUB_M:1];
            exp_adj = exp_q;
        end else begin
            mant    = quotient[`FPHUB_M-1:0];
            exp_adj = exp_q - fphub_format_pkg::fphub_exp_calc_t'(1);
        end

        // Range check, truncation is already the HUB rounding
        if (exp_adj > fphub_format_pkg::fphub_exp_calc_t'(`FPHUB_EXP_MAX - 1)) begin
            norm_word = {sign_q, {`FPHUB_E{1'b1}}, {`FPHUB_M{1'b0}}};
        end else if (exp_adj < fphub_format_pkg::fphub_exp_calc_t'(1)) begin
            norm_word = {sign_q, {`FPHUB_E{1'b0}}, {`FPHUB_M{1'b0}}};
        end else begin
            norm_word = {sign_q, exp_adj[`FPHUB_E-1:0], mant};
        end
    end

    // Capture on the strobe edge, special_res is only valid then
    always_ff @(posedge clk) begin
        if (load_special) begin
            stage_q <= special_res;
        end else if (pack) begin
            stage_q <= norm_word;
        end
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            pend_q <= 1'b0;
            finish <= 1'b0;
            res    <= '0;
        end else begin
            pend_q <= load_special | pack;
            // Single-cycle finish, res holds until the next one
            finish <= pend_q;
            if (pend_q) begin
                res <= stage_q;
            end
        end
    end

endmodule

// File: source/fphub_divider.sv
// Top level of the HUB floating-point SRT divider, instantiated by the testbench as the DUT
`timescale 1ns/1ps

module fphub_divider (
    input  logic                         clk,
    input  logic                         rst_l,
    input  logic                         start,
    input  fphub_format_pkg::fphub_word_t x,
    input  fphub_format_pkg::fphub_word_t d,
    output fphub_format_pkg::fphub_word_t res,
    output logic                         finish,
    output logic                         busy
);

    // Classification to control and packing
    logic                          is_special;
    fphub_format_pkg::fphub_word_t special_res;

    // Control strobes
    logic load_normal;
    logic load_special;
    logic iterate;
    logic pack;

    // Corrected SRT quotient
    fphub_format_pkg::fphub_quot_t quotient;

    fphub_special_cases u_special (
        .x          (x),
        .d          (d),
        .is_special (is_special),
        .special_res(special_res)
    );

    srt_control u_control (
        .clk         (clk),
        .rst_l       (rst_l),
        .start       (start),
        .is_special  (is_special),
        .load_normal (load_normal),
        .load_special(load_special),
        .iterate     (iterate),
        .pack        (pack),
        .busy        (busy)
    );

    srt_datapath u_datapath (
        .clk        (clk),
        .rst_l      (rst_l),
        .load_normal(load_normal),
        .iterate    (iterate),
        .x          (x),
        .d          (d),
        .quotient   (quotient)
    );

    fphub_result_pack u_pack (
        .clk         (clk),
        .rst_l       (rst_l),
        .load_normal (load_normal),
        .load_special(load_special),
        .pack        (pack),
        .x           (x),
        .d           (d),
        .special_res (special_res),
        .quotient    (quotient),
        .res         (res),
        .finish      (finish)
    );

endmodule

// File: verification/fphub_divider_assertions.sv
// Concurrent checks on the divider strobes, bound into every fphub_divider instance
`timescale 1ns/1ps

module fphub_divider_assertions (
    input logic clk,
    input logic rst_l,
    input logic start,
    input logic busy,
    input logic finish
);

    // Finish is a one-cycle strobe
    assert property (@(posedge clk) disable iff (!rst_l) finish |=> !finish)
        else $error("finish stayed high for two consecutive cycles");

    // Leaving reset with both status outputs low
    assert property (@(posedge clk) $rose(rst_l) |-> (!busy && !finish))
        else $error("busy or finish high right after reset");

    // A start during an operation is dropped
    // busy only falls with the finish of the running operation
    assert property (@(posedge clk) disable iff (!rst_l) (start && busy) |=> (busy || finish))
        else $error("start while busy ended the operation early");

    // Busy has already fallen when the result appears
    assert property (@(posedge clk) disable iff (!rst_l) finish |-> !busy)
        else $error("busy high in the finish cycle");

endmodule

bind fphub_divider fphub_divider_assertions u_assertions (
    .clk   (clk),
    .rst_l (rst_l),
    .start (start),
    .busy  (busy),
    .finish(finish)
);

// File: verification/tb_fphub_divider.sv
// Self-checking testbench for the HUB divider, run as the simulation top with the bound assertions
`timescale 1ns/1ps
`include "fphub_defines.svh"

module tb_fphub_divider;

    localparam int N_TABLE = 24;
    localparam int N_RAND  = 40;
    // Reset, every operation at worst-case length, the busy test counted twice, margin
    localparam int TIMEOUT_CYCLES = 16 + (N_TABLE + N_RAND + 2) * (`SRT_LATENCY + 4) + 100;

    // Directed vectors {special, x, d, expected res}, worked out by hand
    localparam logic [96:0] VECTORS [N_TABLE] = '{
        // Normal, both normalization branches
        {1'b0, 32'h3FC00000, 32'h3FA00000, 32'h3F999999},
        {1'b0, 32'h3FA00000, 32'h3FC00000, 32'h3F555555},
        {1'b0, 32'hBFC00000, 32'h3FA00000, 32'hBF999999},
        {1'b0, 32'h3F800000, 32'h3F800000, 32'h3F800000},
        {1'b0, 32'h3F800000, 32'h3FC00000, 32'h3F2AAAAA},
        {1'b0, 32'h7F000000, 32'h3F800000, 32'h7F000000},
        // Overflow to inf, underflow to zero
        {1'b0, 32'h7F000000, 32'h00800000, 32'h7F800000},
        {1'b0, 32'hFF000000, 32'h00800000, 32'hFF800000},
        {1'b0, 32'h7F000000, 32'h3F000000, 32'h7F800000},
        {1'b0, 32'h00800000, 32'h7F000000, 32'h00000000},
        {1'b0, 32'h00800000, 32'hFF000000, 32'h80000000},
        {1'b0, 32'h00800000, 32'h40000000, 32'h00000000},
        // NaN in, 0/0, inf/inf
        {1'b1, 32'h7FC00000, 32'h3F800000, 32'h7FFFFFFF},
        {1'b1, 32'h3F800000, 32'hFFC00001, 32'h7FFFFFFF},
        {1'b1, 32'h00000000, 32'h80000000, 32'h7FFFFFFF},
        {1'b1, 32'hFF800000, 32'h7F800000, 32'h7FFFFFFF},
        // 0/x and x/inf give signed zero
        {1'b1, 32'h00000000, 32'hBF800000, 32'h80000000},
        {1'b1, 32'h80000000, 32'hBF800000, 32'h00000000},
        {1'b1, 32'h3F800000, 32'hFF800000, 32'h80000000},
        {1'b1, 32'hBF800000, 32'hFF800000, 32'h00000000},
        // x/0 and inf/x give signed inf
        {1'b1, 32'h3F800000, 32'h00000000, 32'h7F800000},
        {1'b1, 32'hBF800000, 32'h00000000, 32'hFF800000},
        {1'b1, 32'h7F800000, 32'hBF800000, 32'hFF800000},
        {1'b1, 32'hFF800000, 32'hBF800000, 32'h7F800000}
    };

    logic                          clk;
    logic                          rst_l;
    logic                          start;
    fphub_format_pkg::fphub_word_t x;
    fphub_format_pkg::fphub_word_t d;
    fphub_format_pkg::fphub_word_t res;
    logic                          finish;
    logic                          busy;

    int          cycle        = 0;
    int          finish_count = 0;
    int          res_errors   = 0;
    int          lat_errors   = 0;
    int          other_errors = 0;
    logic [31:0] lfsr_state   = 32'd59;

    fphub_divider UUT (
        .clk   (clk),
        .rst_l (rst_l),
        .start (start),
        .x     (x),
        .d     (d),
        .res   (res),
        .finish(finish),
        .busy  (busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // Every finish strobe, sampled mid-cycle
    always @(negedge clk) begin
        if (finish === 1'b1) begin
            finish_count <= finish_count + 1;
        end
    end

    always @(negedge clk) begin
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the test sequence did not complete", cycle);
            $display("Simulation failed");
            $finish;
        end
    end

    // Galois LFSR, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic next_random_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h80200003;
        end
        return out;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], next_random_bit()};
        end
        return r;
    endfunction

    // Normal operand, exponent 96..159 keeps most quotients in range
    function automatic fphub_format_pkg::fphub_word_t random_operand();
        logic [31:0] bits;
        logic        s;
        logic [5:0]  e_off;
        logic [22:0] m;
        bits  = random_bits(1);
        s     = bits[0];
        bits  = random_bits(6);
        e_off = bits[5:0];
        bits  = random_bits(23);
        m     = bits[22:0];
        return {s, 8'd96 + {2'b00, e_off}, m};
    endfunction

    // Reference Q = floor(Sx * 2^24 / Sd) by wide integer division
    function automatic fphub_format_pkg::fphub_word_t expected_quotient(
        input fphub_format_pkg::fphub_word_t a,
        input fphub_format_pkg::fphub_word_t b
    );
        logic [63:0] sig_a;
        logic [63:0] sig_b;
        logic [63:0] q;
        logic        s;
        int          e;
        sig_a = {39'd0, 1'b1, a[22:0], 1'b1};
        sig_b = {39'd0, 1'b1, b[22:0], 1'b1};
        q     = (sig_a << 24) / sig_b;
        s     = a[31] ^ b[31];
        e     = int'(a[30:23]) - int'(b[30:23]) + `FPHUB_BIAS;
        if (q < (64'd1 << 24)) begin
            e = e - 1;
            q = q << 1;
        end
        if (e > 254) begin
            return {s, 8'hFF, 23'd0};
        end
        if (e < 1) begin
            return {s, 8'h00, 23'd0};
        end
        return {s, e[7:0], q[23:1]};
    endfunction

    task automatic check_res(
        input fphub_format_pkg::fphub_word_t expected,
        input fphub_format_pkg::fphub_word_t actual
    );
        if (actual !== expected) begin
            res_errors++;
            $display("FAILED time=%0t signal=res expected=%h actual=%h", $time, expected, actual);
        end
    endtask

    task automatic check_latency(input int expected, input int actual);
        if (actual !== expected) begin
            lat_errors++;
            $display("FAILED time=%0t signal=latency expected=%0d actual=%0d",
                     $time, expected, actual);
        end
    endtask

    // Start for one cycle, return the cycle of the accepting edge
    task automatic issue_start(
        input  fphub_format_pkg::fphub_word_t a,
        input  fphub_format_pkg::fphub_word_t b,
        output int                            accept_cycle
    );
        @(posedge clk);
        x     <= a;
        d     <= b;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        accept_cycle = cycle;
    endtask

    task automatic wait_finish(
        input  int                            accept_cycle,
        output fphub_format_pkg::fphub_word_t r,
        output int                            lat
    );
        do begin
            @(negedge clk);
        end while (finish !== 1'b1 && cycle - accept_cycle < `SRT_LATENCY + 4);
        if (finish !== 1'b1) begin
            other_errors++;
            $display("No finish within %0d cycles of the start accepted at cycle %0d",
                     `SRT_LATENCY + 4, accept_cycle);
        end
        lat = cycle - accept_cycle;
        r   = res;
    endtask

    initial begin
        fphub_format_pkg::fphub_word_t got;
        fphub_format_pkg::fphub_word_t ra;
        fphub_format_pkg::fphub_word_t rb;
        int                            acc;
        int                            lat;
        int                            finishes_before;
        rst_l = 1'b0;
        start = 1'b0;
        x     = '0;
        d     = '0;
        repeat (16) @(posedge clk);
        rst_l <= 1'b1;
        @(negedge clk);
        check_res('0, res);

        for (int i = 0; i < N_TABLE; i++) begin
            issue_start(VECTORS[i][95:64], VECTORS[i][63:32], acc);
            wait_finish(acc, got, lat);
            check_res(VECTORS[i][31:0], got);
            check_latency(VECTORS[i][96] ? 1 : `SRT_LATENCY, lat);
        end

        for (int i = 0; i < N_RAND; i++) begin
            ra = random_operand();
            rb = random_operand();
            issue_start(ra, rb, acc);
            wait_finish(acc, got, lat);
            check_res(expected_quotient(ra, rb), got);
            check_latency(`SRT_LATENCY, lat);
        end

        // Second start mid-iteration, x/0 would finish at once if taken
        issue_start(32'h3FC00000, 32'h3FA00000, acc);
        // Previous finish already counted, nothing new can finish yet
        finishes_before = finish_count;
        repeat (3) @(posedge clk);
        x     <= 32'h3F800000;
        d     <= 32'h00000000;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        if (busy !== 1'b1) begin
            other_errors++;
            $display("busy dropped after a start given during an operation");
        end
        wait_finish(acc, got, lat);
        check_res(32'h3F999999, got);
        check_latency(`SRT_LATENCY, lat);
        repeat (`SRT_LATENCY + 4) @(negedge clk);
        if (finish_count - finishes_before != 1) begin
            other_errors++;
            $display("Start during busy gave %0d finish strobes instead of one",
                     finish_count - finishes_before);
        end

        $display("Errors: res %0d, latency %0d, other %0d", res_errors, lat_errors, other_errors);
        if (res_errors + lat_errors + other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+common
common/fphub_format_pkg.sv
common/srt_pkg.sv
source/fphub_special_cases.sv
srt_divider/srt_control.sv
srt_divider/srt_datapath.sv
source/fphub_result_pack.sv
source/fphub_divider.sv
verification/fphub_divider_assertions.sv
verification/tb_fphub_divider.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_fphub_divider
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_MSG   ?= Simulation passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
